// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the VGA test-pattern testbench with Verilator
# Exit status is 0 only when the log holds the pass line

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_vga_test_pattern

if ! verilator --binary --timing --assert \
    -f vga_test_pattern.f \
    --top-module "$TOP" \
    -Mdir obj_dir -o "$TOP"; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if [ "$sim_status" -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "test passed" "$LOG"; then
  exit 0
else
  echo "Pass line not found in $LOG"
  exit 1
fi

// ==== src/vga_apb_regs.sv ====
// VGA control registers on APB
// Pattern select register and read-only frame counter

`timescale 1ns/1ps

module vga_apb_regs (
  input  logic              i_Clk,
  input  logic              i_rst_n,
  input  vga_pkg::apb_req_t i_apb,
  output vga_pkg::apb_rsp_t o_apb,
  input  logic              i_frame_start,
  output logic [3:0]        o_pattern
);

  import vga_pkg::*;

  logic [3:0]  r_ctrl;
  logic [15:0] r_frame_cnt;
  logic [31:0] r_prdata;
  logic        r_pslverr;
  logic        w_setup;
  logic        w_access_wr;
  logic        w_hit_ctrl;
  logic        w_hit_cnt;
  logic        w_err;
  logic [31:0] w_rd_mux;

  // Phase decode
  assign w_setup     = i_apb.psel & ~i_apb.penable;
  assign w_access_wr = i_apb.psel & i_apb.penable & i_apb.pwrite;

  assign w_hit_ctrl = (i_apb.paddr == ADDR_CTRL);
  assign w_hit_cnt  = (i_apb.paddr == ADDR_FRAME_CNT);
  // Unmapped address, or write to the read-only counter
  assign w_err      = ~(w_hit_ctrl | w_hit_cnt) | (w_hit_cnt & i_apb.pwrite);

  assign w_rd_mux = w_hit_ctrl ? {28'd0, r_ctrl} :
                    w_hit_cnt  ? {16'd0, r_frame_cnt} : 32'd0;

  ////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////
  always_ff @(posedge i_Clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      r_ctrl      <= PAT_OFF;
      r_frame_cnt <= '0;
      r_prdata    <= '0;
      r_pslverr   <= 1'b0;
    end
    else
    begin
      // Write lands in the access phase
      if (w_access_wr && w_hit_ctrl)
        r_ctrl <= i_apb.pwdata[3:0];
      if (i_frame_start)
        r_frame_cnt <= r_frame_cnt + 1'b1;
      // Response loaded in setup, valid through access
      r_pslverr <= w_setup & w_err;
      r_prdata  <= (w_setup && !i_apb.pwrite) ? w_rd_mux : 32'd0;
    end
  end

  // No wait states
  assign o_apb = '{prdata: r_prdata, pready: 1'b1, pslverr: r_pslverr};

  assign o_pattern = r_ctrl;

endmodule

// ==== src/vga_pattern_gen.sv ====
// VGA pattern generator
// Builds all seven patterns at once and registers the chosen pixel with its syncs

`timescale 1ns/1ps

module vga_pattern_gen #(
  parameter int ACTIVE_COLS = 640,
  parameter int ACTIVE_ROWS = 480
) (
  input  logic                i_Clk,
  input  logic                i_rst_n,
  input  vga_pkg::vga_pos_t   i_pos,
  input  logic                i_frame_start,
  input  logic [3:0]          i_pattern,
  output vga_pkg::vga_sync_t  o_sync,
  output vga_pkg::vga_pixel_t o_pixel
);

  import vga_pkg::*;

  localparam logic [COUNT_W-1:0]     ACT_COLS = COUNT_W'(ACTIVE_COLS);
  localparam logic [COUNT_W-1:0]     ACT_ROWS = COUNT_W'(ACTIVE_ROWS);
  localparam logic [COUNT_W-1:0]     BAR_W    = COUNT_W'(ACTIVE_COLS / 8);
  localparam logic [VIDEO_WIDTH-1:0] FULL     = '1;

  pattern_e   r_pattern;
  pattern_e   w_pattern;
  logic       w_active;
  logic       w_check_on;
  logic       w_border_on;
  logic [2:0] w_bar_idx;
  vga_pixel_t w_pix_checker;
  vga_pixel_t w_pix_bars;
  vga_pixel_t w_pix_border;
  vga_pixel_t w_pix_sel;

  ////////////////////////////////////////////////////////////
  // Pattern choice held for a whole frame
  ////////////////////////////////////////////////////////////
  always_ff @(posedge i_Clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
      r_pattern <= PAT_OFF;
    else if (i_frame_start)
      r_pattern <= pattern_e'(i_pattern);
  end

  // Pixel 0,0 already uses the choice taken at its own frame start
  assign w_pattern = i_frame_start ? pattern_e'(i_pattern) : r_pattern;

  assign w_active = (i_pos.col < ACT_COLS) && (i_pos.row < ACT_ROWS);

  ////////////////////////////////////////////////////////////
  // Parallel pattern sources
  ////////////////////////////////////////////////////////////
  // Squares of 32 pixels
  assign w_check_on    = i_pos.col[5] ^ i_pos.row[5];
  assign w_pix_checker = w_check_on ? {FULL, FULL, FULL} : '0;

  // Bar index, col divided by bar width
  always_comb
  begin
    w_bar_idx = 3'd0;
    for (int i = 1; i < 8; i++)
    begin
      if (i_pos.col >= BAR_W * COUNT_W'(i))
        w_bar_idx = 3'(i);
    end
  end

  // Index bits map straight to R, G, B
  assign w_pix_bars.red = w_bar_idx[2] ? FULL : '0;
  assign w_pix_bars.grn = w_bar_idx[1] ? FULL : '0;
  assign w_pix_bars.blu = w_bar_idx[0] ? FULL : '0;

  // Two-pixel frame around the active area
  assign w_border_on  = (i_pos.row <= 1) || (i_pos.row >= ACT_ROWS - 2) ||
                        (i_pos.col <= 1) || (i_pos.col >= ACT_COLS - 2);
  assign w_pix_border = w_border_on ? {FULL, FULL, FULL} : '0;

  ////////////////////////////////////////////////////////////
  // Selection, blanked outside the active area
  ////////////////////////////////////////////////////////////
  always_comb
  begin
    w_pix_sel = '0;
    if (w_active)
    begin
      case (w_pattern)
        PAT_RED:     w_pix_sel.red = FULL;
        PAT_GREEN:   w_pix_sel.grn = FULL;
        PAT_BLUE:    w_pix_sel.blu = FULL;
        PAT_CHECKER: w_pix_sel = w_pix_checker;
        PAT_BARS:    w_pix_sel = w_pix_bars;
        PAT_BORDER:  w_pix_sel = w_pix_border;
        // Off and unknown codes stay black
        default:     w_pix_sel = '0;
      endcase
    end
  end

  // Pixel and markers registered together
  always_ff @(posedge i_Clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      o_sync  <= '0;
      o_pixel <= '0;
    end
    else
    begin
      o_sync  <= i_pos.sync;
      o_pixel <= w_pix_sel;
    end
  end

endmodule

// ==== src/vga_pkg.sv ====
// VGA test-pattern shared definitions
// Colour depth, counter width, pattern opcodes, bus structs and register map

package vga_pkg;

  // Bits per colour channel
  localparam int VIDEO_WIDTH = 4;
  // Column and row counter width, totals up to 1023
  localparam int COUNT_W = 10;

  // Pattern opcodes, unlisted codes display as off
  typedef enum logic [3:0] {
    PAT_OFF     = 4'd0,
    PAT_RED     = 4'd1,
    PAT_GREEN   = 4'd2,
    PAT_BLUE    = 4'd3,
    PAT_CHECKER = 4'd4,
    PAT_BARS    = 4'd5,
    PAT_BORDER  = 4'd6
  } pattern_e;

  // Active-region markers, high inside the visible area
  typedef struct packed {
    logic hsync;
    logic vsync;
  } vga_sync_t;

  // Pixel position travelling with its own markers
  typedef struct packed {
    logic [COUNT_W-1:0] col;
    logic [COUNT_W-1:0] row;
    vga_sync_t          sync;
  } vga_pos_t;

  typedef struct packed {
    logic [VIDEO_WIDTH-1:0] red;
    logic [VIDEO_WIDTH-1:0] grn;
    logic [VIDEO_WIDTH-1:0] blu;
  } vga_pixel_t;

  ////////////////////////////////////////////////////////////
  // APB request and response
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  // Register map
  localparam logic [7:0] ADDR_CTRL      = 8'h00;
  localparam logic [7:0] ADDR_FRAME_CNT = 8'h04;

endpackage

// ==== src/vga_sync_to_count.sv ====
// VGA sync decoder
// Rebuilds column and row counts and a frame-start pulse from sync markers

`timescale 1ns/1ps

module vga_sync_to_count #(
  parameter int TOTAL_COLS = 800,
  parameter int TOTAL_ROWS = 525
) (
  input  logic                i_Clk,
  input  logic                i_rst_n,
  input  vga_pkg::vga_sync_t  i_sync,
  output vga_pkg::vga_pos_t   o_pos,
  output logic                o_frame_start
);

  import vga_pkg::*;

  localparam logic [COUNT_W-1:0] LAST_COL = COUNT_W'(TOTAL_COLS - 1);
  localparam logic [COUNT_W-1:0] LAST_ROW = COUNT_W'(TOTAL_ROWS - 1);

  logic r_vsync_d;
  logic w_vsync_rise;

  // Frame begins where vsync goes high
  assign w_vsync_rise = i_sync.vsync & ~r_vsync_d;

  always_ff @(posedge i_Clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      r_vsync_d     <= 1'b0;
      o_pos         <= '0;
      o_frame_start <= 1'b0;
    end
    else
    begin
      r_vsync_d     <= i_sync.vsync;
      o_frame_start <= w_vsync_rise;
      // Sync sample rides with the count it belongs to
      o_pos.sync    <= i_sync;
      if (w_vsync_rise)
      begin
        // Origin of the new frame
        o_pos.col <= '0;
        o_pos.row <= '0;
      end
      else if (o_pos.col == LAST_COL)
      begin
        o_pos.col <= '0;
        if (o_pos.row == LAST_ROW)
          o_pos.row <= '0;
        else
          o_pos.row <= o_pos.row + 1'b1;
      end
      else
      begin
        o_pos.col <= o_pos.col + 1'b1;
      end
    end
  end

endmodule

// ==== src/vga_test_pattern_top.sv ====
// VGA test-pattern subsystem top
// Timing source, sync decoder, pattern generator and APB registers

`timescale 1ns/1ps

module vga_test_pattern_top #(
  parameter int TOTAL_COLS  = 800,
  parameter int TOTAL_ROWS  = 525,
  parameter int ACTIVE_COLS = 640,
  parameter int ACTIVE_ROWS = 480
) (
  input  logic                i_Clk,
  input  logic                i_rst_n,
  input  vga_pkg::apb_req_t   i_apb,
  output vga_pkg::apb_rsp_t   o_apb,
  output vga_pkg::vga_sync_t  o_sync,
  output vga_pkg::vga_pixel_t o_pixel
);

  import vga_pkg::*;

  vga_sync_t  w_src_sync;
  vga_pos_t   w_pos;
  logic       w_frame_start;
  logic [3:0] w_pattern;

  // Stands in for the external video source
  vga_timing_gen #(
    .TOTAL_COLS  (TOTAL_COLS),
    .TOTAL_ROWS  (TOTAL_ROWS),
    .ACTIVE_COLS (ACTIVE_COLS),
    .ACTIVE_ROWS (ACTIVE_ROWS)
  ) u_timing (
    .i_Clk   (i_Clk),
    .i_rst_n (i_rst_n),
    .o_sync  (w_src_sync)
  );

  vga_sync_to_count #(
    .TOTAL_COLS (TOTAL_COLS),
    .TOTAL_ROWS (TOTAL_ROWS)
  ) u_decode (
    .i_Clk         (i_Clk),
    .i_rst_n       (i_rst_n),
    .i_sync        (w_src_sync),
    .o_pos         (w_pos),
    .o_frame_start (w_frame_start)
  );

  vga_pattern_gen #(
    .ACTIVE_COLS (ACTIVE_COLS),
    .ACTIVE_ROWS (ACTIVE_ROWS)
  ) u_pattern (
    .i_Clk         (i_Clk),
    .i_rst_n       (i_rst_n),
    .i_pos         (w_pos),
    .i_frame_start (w_frame_start),
    .i_pattern     (w_pattern),
    .o_sync        (o_sync),
    .o_pixel       (o_pixel)
  );

  vga_apb_regs u_regs (
    .i_Clk         (i_Clk),
    .i_rst_n       (i_rst_n),
    .i_apb         (i_apb),
    .o_apb         (o_apb),
    .i_frame_start (w_frame_start),
    .o_pattern     (w_pattern)
  );

endmodule

// ==== src/vga_timing_gen.sv ====
// VGA timing generator
// Free-running column and row counters with registered active-region markers

`timescale 1ns/1ps

module vga_timing_gen #(
  parameter int TOTAL_COLS  = 800,
  parameter int TOTAL_ROWS  = 525,
  parameter int ACTIVE_COLS = 640,
  parameter int ACTIVE_ROWS = 480
) (
  input  logic                i_Clk,
  input  logic                i_rst_n,
  output vga_pkg::vga_sync_t  o_sync
);

  import vga_pkg::*;

  // Counter limits sized to the counters
  localparam logic [COUNT_W-1:0] LAST_COL = COUNT_W'(TOTAL_COLS - 1);
  localparam logic [COUNT_W-1:0] LAST_ROW = COUNT_W'(TOTAL_ROWS - 1);
  localparam logic [COUNT_W-1:0] ACT_COLS = COUNT_W'(ACTIVE_COLS);
  localparam logic [COUNT_W-1:0] ACT_ROWS = COUNT_W'(ACTIVE_ROWS);

  logic [COUNT_W-1:0] r_col;
  logic [COUNT_W-1:0] r_row;

  ////////////////////////////////////////////////////////////
  // Nested counters across the whole frame
  ////////////////////////////////////////////////////////////
  always_ff @(posedge i_Clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      r_col <= '0;
      r_row <= '0;
    end
    else if (r_col == LAST_COL)
    begin
      r_col <= '0;
      // Row steps once per line and wraps at frame end
      if (r_row == LAST_ROW)
        r_row <= '0;
      else
        r_row <= r_row + 1'b1;
    end
    else
    begin
      r_col <= r_col + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Markers one cycle behind the count
  ////////////////////////////////////////////////////////////
  always_ff @(posedge i_Clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      o_sync <= '0;
    end
    else
    begin
      o_sync.hsync <= (r_col < ACT_COLS);
      o_sync.vsync <= (r_row < ACT_ROWS);
    end
  end

endmodule

// ==== verification/tb_vga_test_pattern.sv ====
// Testbench for the VGA test-pattern subsystem
// Rebuilds position from the output syncs, checks pixels, sync geometry and APB registers

`timescale 1ns/1ps

module tb_vga_test_pattern;

  import vga_pkg::*;

  // Small frame geometry
  localparam int TOTAL_COLS  = 100;
  localparam int TOTAL_ROWS  = 60;
  localparam int ACTIVE_COLS = 64;
  localparam int ACTIVE_ROWS = 40;
  localparam logic [COUNT_W-1:0] LAST_COL = COUNT_W'(TOTAL_COLS - 1);
  localparam logic [COUNT_W-1:0] LAST_ROW = COUNT_W'(TOTAL_ROWS - 1);
  localparam logic [COUNT_W-1:0] ACT_COLS = COUNT_W'(ACTIVE_COLS);
  localparam logic [COUNT_W-1:0] ACT_ROWS = COUNT_W'(ACTIVE_ROWS);
  // Two whole frames of cycles
  localparam int FRAME_TIMEOUT = 2 * TOTAL_COLS * TOTAL_ROWS;

  logic       i_Clk;
  logic       i_rst_n;
  apb_req_t   i_apb;
  apb_rsp_t   o_apb;
  vga_sync_t  o_sync;
  vga_pixel_t o_pixel;

  // Tracker state for the previous output sample
  logic               prev_vs;
  logic               synced;
  logic [COUNT_W-1:0] trk_col;
  logic [COUNT_W-1:0] trk_row;
  // Pattern armed by the stimulus and pattern of the running frame
  logic               arm_valid;
  logic [3:0]         arm_pat;
  logic               frame_chk;
  logic [3:0]         frame_pat;
  // Expected APB response of the access phase
  logic               rsp_chk;
  logic               chk_data;
  logic [31:0]        exp_rdata;
  logic               exp_err;

  logic [COUNT_W-1:0] step_col;
  logic [COUNT_W-1:0] step_row;
  logic [COUNT_W-1:0] cur_col;
  logic [COUNT_W-1:0] cur_row;
  logic               vs_rise;
  logic               cur_valid;
  logic               cur_active;
  logic               cur_chk;
  logic [3:0]         cur_pat;
  vga_pixel_t         exp_pix;

  vga_test_pattern_top #(
    .TOTAL_COLS  (TOTAL_COLS),
    .TOTAL_ROWS  (TOTAL_ROWS),
    .ACTIVE_COLS (ACTIVE_COLS),
    .ACTIVE_ROWS (ACTIVE_ROWS)
  ) DUT (
    .i_Clk   (i_Clk),
    .i_rst_n (i_rst_n),
    .i_apb   (i_apb),
    .o_apb   (o_apb),
    .o_sync  (o_sync),
    .o_pixel (o_pixel)
  );

  initial
  begin
    i_Clk = 1'b0;
    forever #20 i_Clk = ~i_Clk;
  end

  ////////////////////////////////////////////////////////////
  // Reference pixel from pattern code and position
  ////////////////////////////////////////////////////////////
  function automatic vga_pixel_t pixel_model(input logic [3:0] pat,
                                             input logic [COUNT_W-1:0] col,
                                             input logic [COUNT_W-1:0] row);
    vga_pixel_t pix;
    int         bar;
    logic       edge_on;
    pix = '0;
    bar = int'(col) / (ACTIVE_COLS / 8);
    edge_on = (row <= 10'd1) || (row >= ACT_ROWS - 10'd2) ||
              (col <= 10'd1) || (col >= ACT_COLS - 10'd2);
    if ((col < ACT_COLS) && (row < ACT_ROWS))
    begin
      case (pat)
        PAT_RED:     pix.red = '1;
        PAT_GREEN:   pix.grn = '1;
        PAT_BLUE:    pix.blu = '1;
        PAT_CHECKER: pix = (col[5] != row[5]) ? '1 : '0;
        PAT_BARS:
        begin
          pix.red = bar[2] ? '1 : '0;
          pix.grn = bar[1] ? '1 : '0;
          pix.blu = bar[0] ? '1 : '0;
        end
        PAT_BORDER:  pix = edge_on ? '1 : '0;
        // Off and unknown codes are black
        default:     pix = '0;
      endcase
    end
    return pix;
  endfunction

  // Counting continues from the previous sample
  assign step_col = (trk_col == LAST_COL) ? '0 : trk_col + 1'b1;
  assign step_row = (trk_col != LAST_COL) ? trk_row :
                    (trk_row == LAST_ROW) ? '0 : trk_row + 1'b1;
  // A vsync rise marks column 0, row 0
  assign vs_rise    = o_sync.vsync & ~prev_vs;
  assign cur_col    = vs_rise ? '0 : step_col;
  assign cur_row    = vs_rise ? '0 : step_row;
  assign cur_valid  = synced | vs_rise;
  assign cur_active = (cur_col < ACT_COLS) && (cur_row < ACT_ROWS);
  assign cur_chk    = vs_rise ? arm_valid : frame_chk;
  assign cur_pat    = vs_rise ? arm_pat : frame_pat;
  assign exp_pix    = pixel_model(cur_pat, cur_col, cur_row);

  always @(posedge i_Clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      prev_vs   <= 1'b0;
      synced    <= 1'b0;
      trk_col   <= '0;
      trk_row   <= '0;
      frame_chk <= 1'b0;
      frame_pat <= '0;
    end
    else
    begin
      prev_vs <= o_sync.vsync;
      trk_col <= cur_col;
      trk_row <= cur_row;
      if (vs_rise)
      begin
        synced    <= 1'b1;
        frame_chk <= arm_valid;
        frame_pat <= arm_pat;
      end
    end
  end

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("test failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////
  a_hsync: assert property (@(posedge i_Clk) disable iff (!i_rst_n)
    cur_valid |-> (o_sync.hsync == (cur_col < ACT_COLS)))
  else
    stop_on_error($sformatf("CHECK FAILED o_sync.hsync got %h expected %h at col %0d",
                            o_sync.hsync, (cur_col < ACT_COLS), cur_col));

  a_vsync: assert property (@(posedge i_Clk) disable iff (!i_rst_n)
    cur_valid |-> (o_sync.vsync == (cur_row < ACT_ROWS)))
  else
    stop_on_error($sformatf("CHECK FAILED o_sync.vsync got %h expected %h at row %0d",
                            o_sync.vsync, (cur_row < ACT_ROWS), cur_row));

  // Next rise must land exactly on the frame wrap
  a_frame_len: assert property (@(posedge i_Clk) disable iff (!i_rst_n)
    (synced && vs_rise) |-> ((step_col == '0) && (step_row == '0)))
  else
    stop_on_error($sformatf("CHECK FAILED o_sync.vsync rose at col %h row %h, expected 000 000",
                            step_col, step_row));

  // Black outside the active area and before the first frame
  a_blank: assert property (@(posedge i_Clk) disable iff (!i_rst_n)
    (!cur_valid || !cur_active) |-> (o_pixel == '0))
  else
    stop_on_error($sformatf("CHECK FAILED o_pixel got %h expected 000 outside the active area",
                            o_pixel));

  a_pixel: assert property (@(posedge i_Clk) disable iff (!i_rst_n)
    (cur_valid && cur_chk) |-> (o_pixel == exp_pix))
  else
    stop_on_error($sformatf("CHECK FAILED o_pixel got %h expected %h at col %0d row %0d",
                            o_pixel, exp_pix, cur_col, cur_row));

  // No wait states on the bus
  a_pready: assert property (@(posedge i_Clk) disable iff (!i_rst_n)
    rsp_chk |-> o_apb.pready)
  else
    stop_on_error($sformatf("CHECK FAILED o_apb.pready got %h expected 1", o_apb.pready));

  a_prdata: assert property (@(posedge i_Clk) disable iff (!i_rst_n)
    (rsp_chk && chk_data) |-> (o_apb.prdata == exp_rdata))
  else
    stop_on_error($sformatf("CHECK FAILED o_apb.prdata got %h expected %h",
                            o_apb.prdata, exp_rdata));

  a_pslverr: assert property (@(posedge i_Clk) disable iff (!i_rst_n)
    rsp_chk |-> (o_apb.pslverr == exp_err))
  else
    stop_on_error($sformatf("CHECK FAILED o_apb.pslverr got %h expected %h",
                            o_apb.pslverr, exp_err));

  ////////////////////////////////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////////////////////////////////
  task automatic apb_access(input logic wr, input logic [7:0] addr,
                            input logic [31:0] wdata, input logic chk,
                            input logic [31:0] exp_data, input logic err,
                            output logic [31:0] rdata);
    @(posedge i_Clk);
    i_apb <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
    @(posedge i_Clk);
    // Response assertions sample the access phase
    i_apb.penable <= 1'b1;
    rsp_chk       <= 1'b1;
    chk_data      <= chk;
    exp_rdata     <= exp_data;
    exp_err       <= err;
    // Access phase lasts one cycle
    @(posedge i_Clk);
    rdata = o_apb.prdata;
    i_apb   <= '0;
    rsp_chk <= 1'b0;
  endtask

  task automatic wait_frame_start();
    int n;
    n = 0;
    @(posedge i_Clk);
    while (!vs_rise)
    begin
      n++;
      if (n > FRAME_TIMEOUT)
        stop_on_error("no frame start seen on o_sync.vsync within two frames");
      @(posedge i_Clk);
    end
  endtask

  // Select a pattern and compare the two whole frames after the write
  task automatic show_pattern(input logic [3:0] code);
    logic [31:0] rdata;
    apb_access(1'b1, ADDR_CTRL, {28'd0, code}, 1'b0, 32'd0, 1'b0, rdata);
    // New code expected from the next frame start on
    arm_pat   <= code;
    arm_valid <= 1'b1;
    wait_frame_start();
    wait_frame_start();
    arm_valid <= 1'b0;
  endtask

  initial
  begin
    logic [3:0]  order [0:6];
    logic [3:0]  tmp;
    logic [31:0] rdata;
    logic [31:0] cnt_first;
    int          j;
    void'($urandom(32'h2179_485a));
    i_rst_n   <= 1'b0;
    i_apb     <= '0;
    rsp_chk   <= 1'b0;
    chk_data  <= 1'b0;
    exp_rdata <= '0;
    exp_err   <= 1'b0;
    // Frames right after reset must be black
    arm_valid <= 1'b1;
    arm_pat   <= PAT_OFF;
    repeat (8) @(posedge i_Clk);
    i_rst_n <= 1'b1;

    apb_access(1'b0, ADDR_CTRL, 32'd0, 1'b1, 32'd0, 1'b0, rdata);
    wait_frame_start();
    wait_frame_start();
    arm_valid <= 1'b0;

    // Random order of codes 0 to 6
    for (int i = 0; i < 7; i++)
      order[i] = 4'(i);
    for (int i = 6; i > 0; i--)
    begin
      j = int'($urandom_range(i, 0));
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    for (int i = 0; i < 7; i++)
      show_pattern(order[i]);
    // Unknown code
    show_pattern(4'd9);

    // Only the low nibble of CTRL is kept
    apb_access(1'b1, ADDR_CTRL, 32'hFFFF_FFF5, 1'b0, 32'd0, 1'b0, rdata);
    apb_access(1'b0, ADDR_CTRL, 32'd0, 1'b1, 32'd5, 1'b0, rdata);

    // Unmapped read and counter write leave CTRL untouched
    apb_access(1'b0, 8'h10, 32'd0, 1'b0, 32'd0, 1'b1, rdata);
    apb_access(1'b1, ADDR_FRAME_CNT, 32'h0000_0003, 1'b0, 32'd0, 1'b1, rdata);
    apb_access(1'b0, ADDR_CTRL, 32'd0, 1'b1, 32'd5, 1'b0, rdata);

    // Counter read just after a frame start keeps clear of the next increment
    wait_frame_start();
    apb_access(1'b0, ADDR_FRAME_CNT, 32'd0, 1'b0, 32'd0, 1'b0, cnt_first);
    repeat (3) wait_frame_start();
    apb_access(1'b0, ADDR_FRAME_CNT, 32'd0, 1'b1,
               {16'd0, cnt_first[15:0] + 16'd3}, 1'b0, rdata);

    $display("test passed");
    $finish;
  end

endmodule

// ==== vga_test_pattern.f ====
src/vga_pkg.sv
src/vga_timing_gen.sv
src/vga_sync_to_count.sv
src/vga_pattern_gen.sv
src/vga_apb_regs.sv
src/vga_test_pattern_top.sv
verification/tb_vga_test_pattern.sv
